/* Makefile */
# Verilator flow for the alien formation renderer
# Override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR  ?= verilator
TOP        ?= alien_formation_tb
FILE_LIST  ?= verilog.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_TEXT  ?= Everything OK

SOURCES := $(shell cat $(FILE_LIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TOP)

$(BINARY): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILE_LIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# Pass only if the run prints the pass message
sim: $(BINARY)
	@output="$$(./$(BINARY))"; \
	echo "$$output"; \
	echo "$$output" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* hw/alien_formation.sv */
// ##################################################
// Top level of the alien row renderer.
// Takes one pixel coordinate per cycle and returns its intensity
// and slot flags two cycles later.
// ##################################################

`timescale 1ns/100ps
`default_nettype none

module alien_formation #(
    parameter int STEP_CLOCKS = 16000000
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  invaders_pkg::coord_t                pixel_row,
    input  invaders_pkg::coord_t                pixel_column,
    output logic [3:0]                          alien_pixel,
    output logic [invaders_pkg::SLOT_COUNT-1:0] slot_active
);

    import invaders_pkg::*;

    coord_t origin_row;
    coord_t origin_column;

    logic   row_hit;
    local_t local_row;

    logic                       column_hit;
    local_t                     local_column;
    logic [SLOT_INDEX_BITS-1:0] column_slot;

    formation_motion #(
        .STEP_CLOCKS (STEP_CLOCKS)
    ) i_motion (
        .clk           (clk),
        .arst_n        (arst_n),
        .origin_row    (origin_row),
        .origin_column (origin_column)
    );

    // Single window vertically, its slot index is not needed
    axis_window #(
        .SLOT_WINDOWS (1),
        .PITCH        (SPRITE_SIZE)
    ) i_row_window (
        .clk          (clk),
        .arst_n       (arst_n),
        .origin       (origin_row),
        .position     (pixel_row),
        .in_window    (row_hit),
        .local_offset (local_row),
        .slot_index   ()
    );

    axis_window #(
        .SLOT_WINDOWS (SLOT_COUNT),
        .PITCH        (SLOT_PITCH)
    ) i_column_window (
        .clk          (clk),
        .arst_n       (arst_n),
        .origin       (origin_column),
        .position     (pixel_column),
        .in_window    (column_hit),
        .local_offset (local_column),
        .slot_index   (column_slot)
    );

    sprite_composer i_composer (
        .clk          (clk),
        .arst_n       (arst_n),
        .row_hit      (row_hit),
        .column_hit   (column_hit),
        .local_row    (local_row),
        .local_column (local_column),
        .column_slot  (column_slot),
        .alien_pixel  (alien_pixel),
        .slot_active  (slot_active)
    );

endmodule

`default_nettype wire

/* hw/axis_window.sv */
// ##################################################
// Locates a coordinate within a run of equally spaced windows
// along one axis. One instance serves rows, another columns.
// Result is registered, one cycle after the coordinate.
// ##################################################

`timescale 1ns/100ps
`default_nettype none

module axis_window #(
    parameter int SLOT_WINDOWS = 1,
    parameter int PITCH = invaders_pkg::SLOT_PITCH,
    localparam int INDEX_BITS = (SLOT_WINDOWS > 1) ? $clog2(SLOT_WINDOWS) : 1
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  invaders_pkg::coord_t origin,
    input  invaders_pkg::coord_t position,
    output logic                 in_window,
    output invaders_pkg::local_t local_offset,
    output logic [INDEX_BITS-1:0] slot_index
);

    import invaders_pkg::*;

    logic                  hit_next;
    logic [INDEX_BITS-1:0] index_next;
    local_t                offset_next;

    // Window s covers origin + s*PITCH < position <= origin + s*PITCH + 16
    always_comb
    begin
        int rel;
        hit_next = 1'b0;
        index_next = '0;
        offset_next = '0;
        for (int s = 0; s < SLOT_WINDOWS; s++)
        begin
            rel = int'(position) - int'(origin) - s * PITCH - 1;
            if ((rel >= 0) && (rel < SPRITE_SIZE))
            begin
                hit_next = 1'b1;
                index_next = INDEX_BITS'(s);
                offset_next = local_t'(rel);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            in_window <= 1'b0;
        end
        else
        begin
            in_window <= hit_next;
        end
    end

    // Offset and index are only meaningful with in_window set
    always_ff @(posedge clk)
    begin
        local_offset <= offset_next;
        slot_index <= index_next;
    end

    // Registered slot and offset lead back to the sampled position
    a_hit_matches_position : assert property (
        @(posedge clk) disable iff (!arst_n)
        in_window |->
            (int'($past(position)) - int'($past(origin)) ==
             int'(slot_index) * PITCH + int'(local_offset) + 1)
    );

endmodule

`default_nettype wire

/* hw/formation_motion.sv */
// ##################################################
// Moves the formation origin on a fixed cadence.
// Every STEP_CLOCKS cycles the origin steps sideways, or drops
// and turns around once it has passed a screen edge.
// ##################################################

`timescale 1ns/100ps
`default_nettype none

module formation_motion #(
    parameter int STEP_CLOCKS = 16000000
) (
    input  logic                 clk,
    input  logic                 arst_n,
    output invaders_pkg::coord_t origin_row,
    output invaders_pkg::coord_t origin_column
);

    import invaders_pkg::*;

    localparam int COUNT_BITS = (STEP_CLOCKS > 1) ? $clog2(STEP_CLOCKS) : 1;

    logic [COUNT_BITS-1:0] step_count;
    logic                  step_now;
    logic                  moving_left;

    coord_t row_next;
    coord_t column_next;
    logic   moving_left_next;

    assign step_now = (step_count == COUNT_BITS'(STEP_CLOCKS - 1));

    // Step decision, based on the origin currently in effect
    always_comb
    begin
        row_next = origin_row;
        column_next = origin_column;
        moving_left_next = moving_left;
        if (moving_left)
        begin
            if (origin_column < LEFT_LIMIT)
            begin
                row_next = origin_row + DROP_ROWS;
                moving_left_next = 1'b0;
            end
            else
            begin
                column_next = origin_column - STEP_COLUMNS;
            end
        end
        else
        begin
            if (origin_column > RIGHT_LIMIT)
            begin
                row_next = origin_row + DROP_ROWS;
                moving_left_next = 1'b1;
            end
            else
            begin
                column_next = origin_column + STEP_COLUMNS;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            step_count <= '0;
            origin_row <= START_ROW;
            origin_column <= START_COLUMN;
            moving_left <= 1'b0;
        end
        else if (step_now)
        begin
            // Counter wraps on the same edge that moves the origin
            step_count <= '0;
            origin_row <= row_next;
            origin_column <= column_next;
            moving_left <= moving_left_next;
        end
        else
        begin
            step_count <= step_count + 1'b1;
        end
    end

    // An edge is caught within one step of its threshold
    a_column_range : assert property (
        @(posedge clk) disable iff (!arst_n)
        (origin_column >= LEFT_LIMIT - STEP_COLUMNS) &&
        (origin_column <= RIGHT_LIMIT + STEP_COLUMNS)
    );

endmodule

`default_nettype wire

/* hw/invaders_pkg.sv */
// ##################################################
// Shared types and constants for the alien formation.
// Screen geometry, motion limits and the alien bitmap live here.
// RTL and testbench both import this package.
// ##################################################

`default_nettype none

package invaders_pkg;

    // Screen coordinate, used for rows, columns and the formation origin
    typedef logic [11:0] coord_t;

    // Offset inside one sprite, 0 to 15
    typedef logic [3:0] local_t;

    // Sprite geometry
    localparam int SPRITE_SIZE = 16;
    localparam int SLOT_PITCH = 20;
    localparam int SLOT_COUNT = 5;
    localparam int SLOT_INDEX_BITS = $clog2(SLOT_COUNT);

    // Origin after reset
    localparam coord_t START_ROW = 12'd20;
    localparam coord_t START_COLUMN = 12'd246;

    // Motion per step
    localparam coord_t STEP_COLUMNS = 12'd12;
    localparam coord_t DROP_ROWS = 12'd24;

    // Edge thresholds on the origin column
    localparam coord_t LEFT_LIMIT = 12'd21;
    localparam coord_t RIGHT_LIMIT = 12'd500;

    // Intensity of a lit pixel; unlit is zero
    localparam logic [3:0] PIXEL_ON = 4'hF;

    // The shape is drawn at half vertical resolution
    localparam int BITMAP_ROW_PAIRS = SPRITE_SIZE / 2;

    // One word per row-pair, bit index is the local column.
    // Row-pair 0 is the top of the alien.
    localparam logic [BITMAP_ROW_PAIRS-1:0][SPRITE_SIZE-1:0] ALIEN_BITMAP = {
        // 7: feet
        16'hCC33,
        // 6: legs
        16'h33CC,
        // 5: knees
        16'h0C30,
        // 4: full width body
        16'hFFFF,
        // 3: eyes
        16'hF3CF,
        // 2
        16'h3FFC,
        // 1
        16'h0FF0,
        // 0: head
        16'h03C0
    };

endpackage

`default_nettype wire

/* hw/sprite_composer.sv */
// ##################################################
// Combines the row and column window results with the alien
// bitmap. Produces the pixel intensity and one-hot slot flags,
// registered one cycle after the window results.
// ##################################################

`timescale 1ns/100ps
`default_nettype none

module sprite_composer (
    input  logic                                     clk,
    input  logic                                     arst_n,
    input  logic                                     row_hit,
    input  logic                                     column_hit,
    input  invaders_pkg::local_t                     local_row,
    input  invaders_pkg::local_t                     local_column,
    input  logic [invaders_pkg::SLOT_INDEX_BITS-1:0] column_slot,
    output logic [3:0]                               alien_pixel,
    output logic [invaders_pkg::SLOT_COUNT-1:0]      slot_active
);

    import invaders_pkg::*;

    logic                  sprite_hit;
    logic [3:0]            pixel_next;
    logic [SLOT_COUNT-1:0] active_next;

    // Pixel lies in a sprite only if both axes agree
    assign sprite_hit = row_hit && column_hit;

    always_comb
    begin
        pixel_next = '0;
        active_next = '0;
        if (sprite_hit)
        begin
            active_next = SLOT_COUNT'(1) << column_slot;
            // Two screen rows per bitmap word
            if (ALIEN_BITMAP[local_row[3:1]][local_column])
            begin
                pixel_next = PIXEL_ON;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            alien_pixel <= '0;
            slot_active <= '0;
        end
        else
        begin
            alien_pixel <= pixel_next;
            slot_active <= active_next;
        end
    end

    // A hit always lands in exactly one existing slot
    a_slot_onehot : assert property (
        @(posedge clk) disable iff (!arst_n)
        $past(sprite_hit) |-> $onehot(slot_active)
    );

    a_pixel_in_slot : assert property (
        @(posedge clk) disable iff (!arst_n)
        (alien_pixel != '0) |-> (slot_active != '0)
    );

endmodule

`default_nettype wire

/* sim/alien_formation_tb.sv */
// ##################################################
// Testbench for the alien formation renderer.
// Probes pixels relative to a tracked formation origin and
// checks intensity and slot flags against the alien bitmap.
// ##################################################

`timescale 1ns/100ps
`default_nettype none

module alien_formation_tb;

    import invaders_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int STEP_CLOCKS = 8;
    localparam int TABLE_SIZE = 17;
    localparam int RANDOM_PROBES = 40;
    localparam int RANDOM_SEED = 68;
    // Three full table runs, the random probes and one reset probe
    localparam int PROBE_BUDGET = 3 * TABLE_SIZE + RANDOM_PROBES + 1;
    localparam int WATCHDOG_CYCLES = PROBE_BUDGET * 4 + 40 * STEP_CLOCKS;

    typedef struct packed {
        int                    row_off;
        int                    col_off;
        logic [3:0]            pixel;
        logic [SLOT_COUNT-1:0] slots;
    } probe_t;

    // Row and column offsets from the origin, expected intensity and slot flags
    probe_t probe_table [TABLE_SIZE] = '{
        // Lit and unlit head pixels
        '{1, 8, 4'hF, 5'b00001},
        '{1, 2, 4'h0, 5'b00001},
        // Eye row of slot 1
        '{7, 21, 4'hF, 5'b00010},
        '{7, 26, 4'h0, 5'b00010},
        '{9, 41, 4'hF, 5'b00100},
        '{4, 56, 4'h0, 5'b00100},
        '{11, 66, 4'hF, 5'b01000},
        '{5, 74, 4'hF, 5'b01000},
        // Feet of the last alien
        '{16, 96, 4'hF, 5'b10000},
        '{14, 85, 4'h0, 5'b10000},
        // Gaps between slots
        '{8, 17, 4'h0, 5'b00000},
        '{8, 20, 4'h0, 5'b00000},
        '{8, 58, 4'h0, 5'b00000},
        // On the origin row or column and just outside the sprites
        '{8, 0, 4'h0, 5'b00000},
        '{0, 8, 4'h0, 5'b00000},
        '{17, 8, 4'h0, 5'b00000},
        '{8, 97, 4'h0, 5'b00000}
    };

    logic                  clk;
    logic                  arst_n;
    coord_t                pixel_row;
    coord_t                pixel_column;
    logic [3:0]            alien_pixel;
    logic [SLOT_COUNT-1:0] slot_active;

    // Origin model advanced once per rising edge
    coord_t origin_row;
    coord_t origin_column;
    logic   moving_left;
    int     step_count;
    int     steps_taken;

    int     check_count;
    int     error_count;
    int     checks_mark;
    int     errors_mark;
    int     table_index;
    probe_t random_probe;

    alien_formation #(
        .STEP_CLOCKS (STEP_CLOCKS)
    ) i_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .pixel_row    (pixel_row),
        .pixel_column (pixel_column),
        .alien_pixel  (alien_pixel),
        .slot_active  (slot_active)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("[FAIL] %0d ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic restart_origin();
        origin_row = START_ROW;
        origin_column = START_COLUMN;
        moving_left = 1'b0;
        step_count = 0;
        steps_taken = 0;
    endtask

    // Edge rule takes priority over a sideways step
    task automatic step_origin();
        if (!moving_left && (origin_column > RIGHT_LIMIT))
        begin
            origin_row = origin_row + DROP_ROWS;
            moving_left = 1'b1;
        end
        else if (moving_left && (origin_column < LEFT_LIMIT))
        begin
            origin_row = origin_row + DROP_ROWS;
            moving_left = 1'b0;
        end
        else if (moving_left)
        begin
            origin_column = origin_column - STEP_COLUMNS;
        end
        else
        begin
            origin_column = origin_column + STEP_COLUMNS;
        end
    endtask

    // Wait for a rising edge and keep the origin model in step
    task automatic next_cycle();
        @(posedge clk);
        if (!arst_n)
        begin
            restart_origin();
        end
        else if (step_count == STEP_CLOCKS - 1)
        begin
            step_count = 0;
            steps_taken++;
            step_origin();
        end
        else
        begin
            step_count++;
        end
    endtask

    // Expected result from the window rule and the bitmap
    function automatic probe_t probe_at(input int row_off, input int col_off);
        probe_t probe;
        int     local_row;
        int     local_column;
        probe.row_off = row_off;
        probe.col_off = col_off;
        probe.pixel = '0;
        probe.slots = '0;
        local_row = row_off - 1;
        if ((local_row >= 0) && (local_row < SPRITE_SIZE))
        begin
            for (int s = 0; s < SLOT_COUNT; s++)
            begin
                local_column = col_off - s * SLOT_PITCH - 1;
                if ((local_column >= 0) && (local_column < SPRITE_SIZE))
                begin
                    probe.slots[s] = 1'b1;
                    if (ALIEN_BITMAP[local_row / 2][local_column])
                    begin
                        probe.pixel = PIXEL_ON;
                    end
                end
            end
        end
        return probe;
    endfunction

    // Window samples on the following edge and the composer one edge later
    task automatic apply_probe(input probe_t probe);
        next_cycle();
        pixel_row <= coord_t'(int'(origin_row) + probe.row_off);
        pixel_column <= coord_t'(int'(origin_column) + probe.col_off);
        next_cycle();
        next_cycle();
        @(negedge clk);
        check_value("alien_pixel", 32'(alien_pixel), 32'(probe.pixel));
        check_value("slot_active", 32'(slot_active), 32'(probe.slots));
    endtask

    task automatic apply_table();
        for (int i = 0; i < TABLE_SIZE; i++)
        begin
            apply_probe(probe_table[i]);
        end
    endtask

    // Outputs stay zero for both cycles of reset
    task automatic hold_reset();
        next_cycle();
        arst_n <= 1'b0;
        restart_origin();
        repeat (2)
        begin
            @(negedge clk);
            check_value("alien_pixel", 32'(alien_pixel), 32'(0));
            check_value("slot_active", 32'(slot_active), 32'(0));
            next_cycle();
        end
        arst_n <= 1'b1;
    endtask

    task automatic start_test();
        checks_mark = check_count;
        errors_mark = error_count;
    endtask

    task automatic report_test(input string name);
        $display("Test %-14s %0d checks, %0d mismatches",
                 name, check_count - checks_mark, error_count - errors_mark);
    endtask

    initial
    begin
        arst_n = 1'b0;
        pixel_row = '0;
        pixel_column = '0;
        check_count = 0;
        error_count = 0;
        restart_origin();
        void'($urandom(RANDOM_SEED));

        start_test();
        hold_reset();
        apply_table();
        report_test("reset_origin");

        // Cycle through the table until the 22nd step
        start_test();
        table_index = 0;
        while (steps_taken < 22)
        begin
            apply_probe(probe_table[table_index]);
            table_index = (table_index + 1) % TABLE_SIZE;
        end
        report_test("march_right");

        start_test();
        while (steps_taken < 23)
        begin
            next_cycle();
        end
        apply_table();
        report_test("edge_turn");

        start_test();
        for (int n = 0; n < RANDOM_PROBES; n++)
        begin
            random_probe = probe_at(int'($urandom_range(0, 21)) - 2,
                                    int'($urandom_range(0, 101)) - 2);
            apply_probe(random_probe);
        end
        report_test("random_probes");

        // Lit pixel first so the reset has something to clear
        start_test();
        apply_probe(probe_table[0]);
        hold_reset();
        apply_table();
        report_test("reset_mid_run");

        $display("Checks: %0d, mismatches: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("Everything OK");
        end
        else
        begin
            $display("Something failed");
        end
        $finish;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
hw/invaders_pkg.sv
hw/formation_motion.sv
hw/axis_window.sv
hw/sprite_composer.sv
hw/alien_formation.sv
sim/alien_formation_tb.sv
